// ==== list.f ====
+incdir+sim
hdl/shift_pkg.sv
hdl/shifter_barrel.sv
hdl/shift_decode.sv
hdl/shift_flags.sv
hdl/shift_unit.sv
sim/tb_shift_unit.sv

// ==== Makefile ====
# Verilator build and run for the shift execution unit

VERILATOR ?= verilator
TOP       ?= tb_shift_unit
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard hdl/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

check:
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_shift_tests.svh ====
// Directed tests for the shift execution unit
// Reset, both instruction forms, latency, back-to-back stream and hold
`ifndef TB_SHIFT_TESTS_SVH
`define TB_SHIFT_TESTS_SVH

    function automatic shift_pkg::shift_instr_t make_imm(input logic [2:0] op, input int amt,
                                                         input logic [TAG_W-1:0] t);
        shift_pkg::shift_instr_t ins;
        logic [31:0]             av;
        av = amt;
        ins.imm.op     = op;
        ins.imm.form   = 1'b0;
        ins.imm.amount = av[shift_pkg::AMT_W-1:0];
        ins.imm.tag    = t;
        return ins;
    endfunction

    function automatic shift_pkg::shift_instr_t make_reg(input logic [2:0] op, input logic sel,
                                                         input logic [TAG_W-1:0] t);
        shift_pkg::shift_instr_t ins;
        logic [31:0]             r;
        r = rand_bits(4);
        ins.regs.op       = op;
        ins.regs.form     = 1'b1;
        ins.regs.byte_sel = sel;
        ins.regs.reserved = r[3:0];  // Random noise the decoder ignores
        ins.regs.tag      = t;
        return ins;
    endfunction

    // Issue one and check its latency and value
    task automatic run_one(input shift_pkg::shift_instr_t ins, input logic [W-1:0] av,
                           input logic [W-1:0] bv, input string label);
        int cycles;
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        instr    = ins;
        a        = av;
        b        = bv;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        cycles   = 1;
        while (!out_valid && cycles < MAX_WAIT) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!out_valid) begin
            report_timeout(label);
        end else begin
            check_value(32'(cycles), 32'd2, {label, " latency"});
            check_result(ins, av, bv, label);
        end
    endtask

    task automatic test_reset();
        check_value(32'(out_valid), 32'd0, "reset out_valid");
        check_value(32'(result), 32'd0, "reset result");
        check_value(32'(tag), 32'd0, "reset tag");
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #2;
            check_value(32'(out_valid), 32'd0, "idle out_valid");
        end
    endtask

    // All eight codes at the edge amounts
    task automatic test_immediate();
        int          amts[5] = '{0, 1, 15, 16, 31};
        logic [31:0] r;
        for (int op = 0; op < 8; op++) begin
            foreach (amts[k]) begin
                r = rand_bits(TAG_W);
                run_one(make_imm(3'(op), amts[k], r[TAG_W-1:0]), W'(rand_bits(W)),
                        W'(rand_bits(W)), $sformatf("imm op %0d amount %0d", op, amts[k]));
            end
        end
    endtask

    // Amount from byte 0 or 1 of b; other byte gets a different amount
    task automatic test_register();
        logic [2:0]   ops[5] = '{shift_pkg::OP_SRL, shift_pkg::OP_SRA, shift_pkg::OP_ROR,
                                 shift_pkg::OP_SLL, shift_pkg::OP_ROL};
        int           amts[6] = '{0, 3, 15, 16, 17, 31};
        logic [W-1:0] bv;
        logic [31:0]  tmp;
        logic [31:0]  r;
        foreach (ops[o]) begin
            foreach (amts[k]) begin
                for (int sel = 0; sel < 2; sel++) begin
                    bv  = W'(rand_bits(W));
                    tmp = amts[k];
                    bv[8*sel +: AW] = tmp[AW-1:0];
                    tmp = (amts[k] + 9) % 32;
                    bv[8*(1-sel) +: AW] = tmp[AW-1:0];
                    r = rand_bits(TAG_W);
                    run_one(make_reg(ops[o], sel[0], r[TAG_W-1:0]), W'(rand_bits(W)), bv,
                            $sformatf("reg op %0d byte %0d amount %0d", ops[o], sel, amts[k]));
                end
            end
        end
    endtask

    task automatic test_latency();
        logic [TAG_W-1:0] tags[4] = '{7'h01, 7'h55, 7'h2a, 7'h7f};
        foreach (tags[k]) begin
            run_one(make_imm(shift_pkg::OP_SLL, k + 2, tags[k]), W'(rand_bits(W)),
                    '0, $sformatf("latency tag %0h", tags[k]));
        end
    endtask

    // 32 on consecutive cycles come back in order one per cycle
    task automatic test_back_to_back();
        shift_pkg::shift_instr_t ins_q[32];
        logic [W-1:0]            a_q[32];
        logic [W-1:0]            b_q[32];
        logic [31:0]             r;
        int                      cycles;
        for (int i = 0; i < 32; i++) begin
            r = rand_bits(5 + TAG_W);
            if (r[3]) ins_q[i] = make_reg(r[2:0], r[4], r[5 +: TAG_W]);
            else      ins_q[i] = make_imm(r[2:0], int'(rand_bits(AW)), r[5 +: TAG_W]);
            a_q[i] = W'(rand_bits(W));
            b_q[i] = W'(rand_bits(W));
        end
        fork
            begin : issue_side
                for (int i = 0; i < 32; i++) begin
                    @(posedge clk);
                    #2;
                    in_valid = 1'b1;
                    instr    = ins_q[i];
                    a        = a_q[i];
                    b        = b_q[i];
                end
                @(posedge clk);
                #2;
                in_valid = 1'b0;
            end
            begin : collect_side
                // Previous result may still sit on the outputs
                @(posedge clk);
                #2;
                cycles = 1;
                while (!out_valid && cycles < MAX_WAIT) begin
                    @(posedge clk);
                    #2;
                    cycles++;
                end
                if (!out_valid) begin
                    report_timeout("back-to-back stream");
                end else begin
                    for (int i = 0; i < 32; i++) begin
                        check_value(32'(out_valid), 32'd1, $sformatf("stream %0d valid", i));
                        check_result(ins_q[i], a_q[i], b_q[i], $sformatf("stream %0d", i));
                        @(posedge clk);
                        #2;
                    end
                    check_value(32'(out_valid), 32'd0, "stream end out_valid");
                end
            end
        join
    endtask

    // Outputs keep the last result while inputs churn with in_valid low
    task automatic test_hold();
        shift_pkg::shift_instr_t ins;
        logic [W-1:0]            av;
        logic [W-1:0]            bv;
        logic [31:0]             r;
        ins = make_imm(shift_pkg::OP_ROL, 5, 7'h3c);
        av  = W'(rand_bits(W));
        bv  = W'(rand_bits(W));
        run_one(ins, av, bv, "hold setup");
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            #2;
            r     = rand_bits(shift_pkg::INSTR_W);
            instr = r[shift_pkg::INSTR_W-1:0];
            a     = W'(rand_bits(W));
            b     = W'(rand_bits(W));
            check_value(32'(out_valid), 32'd0, "hold out_valid");
            check_result(ins, av, bv, $sformatf("hold cycle %0d", k));
        end
    endtask

`endif

// ==== sim/tb_shift_unit.sv ====
// Testbench for the shift execution unit
// Clock, reset, LFSR stimulus, reference model, checker and closing report
`timescale 1ns/1ps

module tb_shift_unit;

    localparam int W        = 16;
    localparam int AW       = $clog2(W) + 1;  // Amount width seen by the shifter
    localparam int TAG_W    = shift_pkg::TAG_W;
    localparam int MAX_WAIT = 20;              // Cycles before a wait gives up

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    shift_pkg::shift_instr_t instr;
    logic [W-1:0]            a;
    logic [W-1:0]            b;
    logic                    out_valid;
    logic [W-1:0]            result;
    logic                    zero;
    logic                    negative;
    logic                    carry;
    logic [TAG_W-1:0]        tag;

    logic [31:0] lfsr_state;
    int          n_checks;
    int          n_errors;
    int          n_timeouts;

    shift_unit #(.WIDTH(W)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .zero      (zero),
        .negative  (negative),
        .carry     (carry),
        .tag       (tag)
    );

    always #20 clk = ~clk;  // 40 ns period

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] nx;
        nx = s >> 1;
        if (s[0]) nx = nx ^ 32'h8020_0003;
        return nx;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeouts++;
        $display("timeout at %0t ns: out_valid never came for %s", $time, what);
    endtask

    // Amount as the instruction defines it
    function automatic int amount_of(input shift_pkg::shift_instr_t ins,
                                     input logic [W-1:0] bv);
        logic [15:0] bw;
        bw = 16'(bv);  // Missing bytes read as zero
        if (!ins.imm.form) return int'(ins.imm.amount) % (1 << AW);
        if (ins.regs.byte_sel) return int'(bw[15:8]) % (1 << AW);
        return int'(bw[7:0]) % (1 << AW);
    endfunction

    // Result and carry straight from the shift and flag rules
    task automatic model_shift(input logic [2:0] op, input logic [W-1:0] d, input int n,
                               output logic [W-1:0] res, output logic c);
        int m;
        m = n % W;
        res = d;
        c = 1'b0;
        case (op)
            shift_pkg::OP_SRL: begin
                res = (n >= W) ? '0 : d >> n;
                if (n >= 1 && n <= W) c = d[n-1];
            end
            shift_pkg::OP_SLL: begin
                res = (n >= W) ? '0 : d << n;
                if (n >= 1 && n <= W) c = d[W-n];
            end
            shift_pkg::OP_SRA: begin
                res = $signed(d) >>> m;
                if (m >= 1) c = d[m-1];
            end
            shift_pkg::OP_ROR: begin
                for (int i = 0; i < W; i++) res[i] = d[(i + m) % W];
                if (m >= 1) c = res[W-1];    // Bit that wrapped to the top
            end
            shift_pkg::OP_ROL: begin
                for (int i = 0; i < W; i++) res[i] = d[(i - m + W) % W];
                if (m >= 1) c = res[0];
            end
            default: res = d;               // None, 101, 111
        endcase
    endtask

    // Compare present DUT outputs with the model
    task automatic check_result(input shift_pkg::shift_instr_t ins, input logic [W-1:0] av,
                                input logic [W-1:0] bv, input string label);
        logic [W-1:0] exp_res;
        logic         exp_c;
        model_shift(ins.imm.op, av, amount_of(ins, bv), exp_res, exp_c);
        check_value(32'(result), 32'(exp_res), {label, " result"});
        check_value(32'(zero), 32'(exp_res == '0), {label, " zero"});
        check_value(32'(negative), 32'(exp_res[W-1]), {label, " negative"});
        check_value(32'(carry), 32'(exp_c), {label, " carry"});
        check_value(32'(tag), 32'(ins.imm.tag), {label, " tag"});
    endtask

    `include "tb_shift_tests.svh"

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        instr      = '0;
        a          = '0;
        b          = '0;
        lfsr_state = 32'hfa70;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_immediate();
        test_register();
        test_latency();
        test_back_to_back();
        test_hold();

        $display("checks %0d, mismatches %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tb_shift_unit

// ==== hdl/shift_unit.sv ====
// Shift execution unit
// Decode stage, barrel shifter with flags, registered result, 2-cycle latency
`timescale 1ns/1ps

module shift_unit #(
    parameter int WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,   // One instruction per strobe
    input  shift_pkg::shift_instr_t     instr,
    input  logic [WIDTH-1:0]            a,
    input  logic [WIDTH-1:0]            b,
    output logic                        out_valid,  // Take result this cycle
    output logic [WIDTH-1:0]            result,
    output logic                        zero,
    output logic                        negative,
    output logic                        carry,
    output logic [shift_pkg::TAG_W-1:0] tag
);

    localparam int AW = $clog2(WIDTH) + 1;

    // Stage 1 registers
    logic                        d_valid;
    logic [2:0]                  d_op;
    logic [WIDTH-1:0]            d_data;
    logic [AW-1:0]               d_amount;
    logic [shift_pkg::TAG_W-1:0] d_tag;

    // Stage 2 combinational
    logic [WIDTH-1:0] sh_out;
    logic             f_zero;
    logic             f_neg;
    logic             f_carry;

    initial begin
        assert (WIDTH >= 4 && WIDTH <= 16 && (WIDTH & (WIDTH - 1)) == 0)
            else $fatal(1, "shift_unit: WIDTH must be 4, 8 or 16");
    end

    shift_decode #(.WIDTH(WIDTH)) u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .a        (a),
        .b        (b),
        .d_valid  (d_valid),
        .d_op     (d_op),
        .d_data   (d_data),
        .d_amount (d_amount),
        .d_tag    (d_tag)
    );

    shifter_barrel #(.WIDTH(WIDTH)) u_shifter (
        .data         (d_data),
        .ctrl         (d_op),
        .shift_amount (d_amount),
        .data_out     (sh_out)
    );

    shift_flags #(.WIDTH(WIDTH)) u_flags (
        .data     (d_data),
        .result   (sh_out),
        .op       (d_op),
        .amount   (d_amount),
        .zero     (f_zero),
        .negative (f_neg),
        .carry    (f_carry)
    );

    // Output stage; holds until the next valid result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            zero      <= 1'b0;
            negative  <= 1'b0;
            carry     <= 1'b0;
            tag       <= '0;
        end else begin
            out_valid <= d_valid;
            if (d_valid) begin
                result   <= sh_out;
                zero     <= f_zero;
                negative <= f_neg;
                carry    <= f_carry;
                tag      <= d_tag;
            end
        end
    end

    // End-to-end latency through both stages
    assert property (@(posedge clk) disable iff (!rst_n) out_valid == $past(in_valid, 2))
        else $error("shift_unit: out_valid not 2 cycles after in_valid");

endmodule : shift_unit

// ==== hdl/shift_flags.sv ====
// Shift result flags
// Zero, negative and last-bit-out carry for each operation
`timescale 1ns/1ps

module shift_flags #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]       data,    // Shifter input
    input  logic [WIDTH-1:0]       result,  // Shifter output
    input  logic [2:0]             op,
    input  logic [$clog2(WIDTH):0] amount,
    output logic                   zero,
    output logic                   negative,
    output logic                   carry
);

    localparam int LW = $clog2(WIDTH);
    localparam int AW = LW + 1;

    logic [AW-1:0] idx_r;    // n-1, low bits also give m-1
    logic [AW-1:0] idx_l;    // WIDTH-n
    logic          in_rng;   // n from 1 to WIDTH
    logic          m_nz;     // n mod WIDTH nonzero

    assign zero     = ~|result;
    assign negative = result[WIDTH-1];

    assign idx_r  = amount - 1'b1;
    assign idx_l  = AW'(WIDTH) - amount;
    assign in_rng = (amount != '0) && (amount <= AW'(WIDTH));
    assign m_nz   = |amount[LW-1:0];

    always_comb begin
        carry = 1'b0;
        case (op)
            shift_pkg::OP_SRL: if (in_rng) carry = data[idx_r[LW-1:0]];
            shift_pkg::OP_SRA: if (m_nz)   carry = data[idx_r[LW-1:0]];  // Bit m-1
            shift_pkg::OP_SLL: if (in_rng) carry = data[idx_l[LW-1:0]];
            // Rotates; the wrapped bit is already at the result's end
            shift_pkg::OP_ROR: if (m_nz)   carry = result[WIDTH-1];
            shift_pkg::OP_ROL: if (m_nz)   carry = result[0];
            default:                       carry = 1'b0;
        endcase
    end

endmodule : shift_flags

// ==== hdl/shift_decode.sv ====
// Shift stage decode
// Splits the instruction, picks the amount, registers stage-1 state
`timescale 1ns/1ps

module shift_decode #(
    parameter int WIDTH = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,   // One-cycle strobe
    input  shift_pkg::shift_instr_t    instr,
    input  logic [WIDTH-1:0]           a,          // Data to shift
    input  logic [WIDTH-1:0]           b,          // Amount source, register form
    output logic                       d_valid,
    output logic [2:0]                 d_op,
    output logic [WIDTH-1:0]           d_data,
    output logic [$clog2(WIDTH):0]     d_amount,
    output logic [shift_pkg::TAG_W-1:0] d_tag
);

    localparam int AW = $clog2(WIDTH) + 1;

    // b widened so byte 1 exists for narrow data paths
    logic [15:0]   b_wide;
    logic [AW-1:0] amt_sel;

    assign b_wide = 16'(b);  // Upper bytes read as zero when WIDTH < 16

    // Form bit chooses the view
    always_comb begin
        if (!instr.imm.form) begin
            amt_sel = instr.imm.amount[AW-1:0];  // Immediate, truncated
        end else if (instr.regs.byte_sel) begin
            amt_sel = b_wide[8 +: AW];           // Low bits of byte 1
        end else begin
            amt_sel = b_wide[0 +: AW];           // Low bits of byte 0
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid  <= 1'b0;
            d_op     <= '0;
            d_data   <= '0;
            d_amount <= '0;
            d_tag    <= '0;
        end else begin
            d_valid <= in_valid;  // Strobe every cycle
            if (in_valid) begin
                d_op     <= instr.imm.op;   // Same bits in both views
                d_data   <= a;
                d_amount <= amt_sel;
                d_tag    <= instr.imm.tag;
            end
        end
    end

    // Valid strobe must stay resolved once out of reset
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(d_valid))
        else $error("shift_decode: d_valid unknown");

endmodule : shift_decode

// ==== hdl/shifter_barrel.sv ====
// Barrel shifter
// Logical, arithmetic and rotating shifts, purely combinational
`timescale 1ns/1ps

module shifter_barrel #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]         data,          // Operand
    input  logic [2:0]               ctrl,          // Opcode, see shift_pkg
    input  logic [$clog2(WIDTH):0]   shift_amount,  // Full amount incl. overflow bit
    output logic [WIDTH-1:0]         data_out
);

    localparam int LW = $clog2(WIDTH);  // Bits of amount mod WIDTH

    // Operand twice, so any rotate is a plain slice
    logic [2*WIDTH-1:0] data_dbl;
    logic [LW-1:0]      amt_mod;        // n mod WIDTH

    // Unrolled rotate results, one entry per amount
    logic [WIDTH-1:0] rot_r [WIDTH];
    logic [WIDTH-1:0] rot_l [WIDTH];

    assign data_dbl = {data, data};
    assign amt_mod  = shift_amount[LW-1:0];  // Drops the overflow bit

    for (genvar i = 0; i < WIDTH; i++) begin : gen_rot
        // Right by i starts at bit i of the doubled word
        assign rot_r[i] = data_dbl[i +: WIDTH];
        // Left by i ends i bits below the top half
        assign rot_l[i] = data_dbl[WIDTH-i +: WIDTH];
    end

    always_comb begin
        // Opcode must be resolved whenever the amount is
        assert #0 ($isunknown(shift_amount) || !$isunknown(ctrl))
            else $error("shifter_barrel: ctrl unknown with known amount");

        case (ctrl)
            shift_pkg::OP_NONE: data_out = data;

            // Full amount, so WIDTH and above clears the word
            shift_pkg::OP_SRL: data_out = data >> shift_amount;

            shift_pkg::OP_SRA: data_out = $signed(data) >>> amt_mod;  // Sign fill

            shift_pkg::OP_ROR: data_out = rot_r[amt_mod];

            shift_pkg::OP_SLL: data_out = data << shift_amount;  // Zero fill

            shift_pkg::OP_ROL: data_out = rot_l[amt_mod];

            default: data_out = data;  // 101, 111 pass through
        endcase
    end

endmodule : shifter_barrel

// ==== hdl/shift_pkg.sv ====
// Shift stage shared definitions
// Opcodes, field widths and the two views of the instruction word
package shift_pkg;

    localparam int INSTR_W = 16;  // Instruction word
    localparam int AMT_W   = 5;   // Immediate amount field, $clog2(16)+1
    localparam int TAG_W   = 7;   // Tag carried with the result

    // Operation codes, same encoding as the barrel shifter ctrl
    localparam logic [2:0] OP_NONE = 3'b000;
    localparam logic [2:0] OP_SRL  = 3'b001;  // Logical right
    localparam logic [2:0] OP_SRA  = 3'b010;  // Arithmetic right
    localparam logic [2:0] OP_ROR  = 3'b011;  // Rotate right
    localparam logic [2:0] OP_SLL  = 3'b100;  // Logical left
    localparam logic [2:0] OP_ROL  = 3'b110;  // Rotate left
    // 101 and 111 fall through as no shift

    // Immediate form, amount in the word
    typedef struct packed {
        logic [2:0]       op;
        logic             form;    // 0 here
        logic [AMT_W-1:0] amount;
        logic [TAG_W-1:0] tag;
    } shift_imm_t;

    // Register form, amount from a byte of operand b
    typedef struct packed {
        logic [2:0]               op;
        logic                     form;      // 1 here
        logic                     byte_sel;  // 0 byte 0, 1 byte 1
        logic [INSTR_W-TAG_W-6:0] reserved;  // Pads view to INSTR_W
        logic [TAG_W-1:0]         tag;
    } shift_regs_t;

    // One word, two readings; op, form and tag sit at the same bits
    typedef union packed {
        shift_imm_t  imm;
        shift_regs_t regs;
    } shift_instr_t;

endpackage : shift_pkg
